// ==== lsu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_chk (
    input wire       clk,
    input wire       reset,
    input wire       data_req,
    input wire       data_addr_ok,
    input wire       data_ok,
    input wire       wb_valid,
    input wire [3:0] wb_we,
    input wire       wb_ex,
    input wire       ms_flush
);

    // a new request only once the memory is free or finishing
    req_no_overlap: assert property (@(posedge clk) disable iff (reset)
        $rose(data_req) |-> (data_addr_ok || data_ok))
        else $error("data_req rose while a response was outstanding");

    fault_no_write: assert property (@(posedge clk) disable iff (reset)
        (wb_valid && wb_ex) |-> (wb_we == 4'h0))
        else $error("faulting commit wrote the register file");

    flush_low_after_reset: assert property (@(posedge clk)
        reset |=> !ms_flush)
        else $error("ms_flush high right after reset");

endmodule

bind lsu_top lsu_chk i_lsu_chk (
    .clk          (clk),
    .reset        (reset),
    .data_req     (data_req),
    .data_addr_ok (data_addr_ok),
    .data_ok      (data_ok),
    .wb_valid     (wb_valid),
    .wb_we        (wb_we),
    .wb_ex        (wb_ex),
    .ms_flush     (ms_flush)
);

`default_nettype wire

// ==== lsu_data_sram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_data_sram (
    input  wire         clk,
    input  wire         reset,
    input  wire         data_req,
    input  wire         data_wr,
    input  wire  [3:0]  data_be,
    input  wire  [31:0] data_addr,
    input  wire  [31:0] data_wdata,
    output logic        data_addr_ok,
    output logic        data_ok,
    output logic [31:0] data_rdata
);

    localparam int AW  = $clog2(`LSU_MEM_WORDS);
    localparam int LAT = `LSU_SRAM_LATENCY;

    logic          pending;
    logic [1:0]    cnt;
    logic          wr_q;
    logic [3:0]    be_q;
    logic [AW-1:0] idx_q;
    logic [31:0]   wdata_q;
    logic [31:0]   mem [`LSU_MEM_WORDS];

    // single outstanding request
    assign data_addr_ok = !pending;
    assign data_ok      = pending && (cnt == 2'd0);
    assign data_rdata   = mem[idx_q];

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            cnt     <= 2'd0;
        end else if (data_req && data_addr_ok) begin
            pending <= 1'b1;
            cnt     <= 2'(LAT - 1);
        end else if (data_ok) begin
            pending <= 1'b0;
        end else if (pending) begin
            cnt <= cnt - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_req && data_addr_ok) begin
            wr_q    <= data_wr;
            be_q    <= data_be;
            idx_q   <= data_addr[AW+1:2];
            wdata_q <= data_wdata;
        end
    end

    // write lands together with data_ok
    always_ff @(posedge clk) begin
        if (data_ok && wr_q) begin
            for (int i = 0; i < 4; i++)
                if (be_q[i])
                    mem[idx_q][i*8 +: 8] <= wdata_q[i*8 +: 8];
        end
    end

endmodule

`default_nettype wire

// ==== lsu_issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_issue_stage
    import lsu_pkg::*;
(
    input  wire          clk,
    input  wire          reset,
    input  wire          in_valid,
    input  wire mem_op_e in_op,
    input  wire [31:0]   in_base,
    input  wire [15:0]   in_offset,
    input  wire [31:0]   in_wdata,
    input  wire [4:0]    in_dest,
    input  wire          ms_allowin,
    input  wire          ms_flush,
    input  wire          data_addr_ok,
    output logic         in_allowin,
    output logic         is_to_ms_valid,
    output mem_op_e      is_op,
    output logic [31:0]  is_addr,
    output logic [4:0]   is_dest,
    output logic         is_ex,
    output logic [4:0]   is_excode,
    output logic         data_req,
    output logic         data_wr,
    output logic [3:0]   data_be,
    output logic [31:0]  data_addr,
    output logic [31:0]  data_wdata
);

    logic        is_valid;
    logic        is_ready_go;
    logic        is_store;
    mem_op_e     op_q;
    logic [31:0] base_q;
    logic [15:0] offset_q;
    logic [31:0] wdata_q;
    logic [4:0]  dest_q;
    mem_word_u   st_word;

    assign is_ready_go    = is_ex || (data_req && data_addr_ok);
    assign is_to_ms_valid = is_valid && is_ready_go && !ms_flush;
    // a flush frees the entry, so a new op may come in
    assign in_allowin     = !is_valid || ms_flush || (is_ready_go && ms_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            is_valid <= 1'b0;
        end else if (in_allowin) begin
            is_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op_q     <= in_op;
            base_q   <= in_base;
            offset_q <= in_offset;
            wdata_q  <= in_wdata;
            dest_q   <= in_dest;
        end
    end

    assign is_op    = op_q;
    assign is_dest  = dest_q;
    assign is_addr  = base_q + {{16{offset_q[15]}}, offset_q};
    assign is_store = (op_q == OP_SW) || (op_q == OP_SB) || (op_q == OP_SH);

    always_comb begin
        case (op_q)
            OP_LW, OP_SW:         is_ex = is_addr[1:0] != 2'b00;
            OP_LH, OP_LHU, OP_SH: is_ex = is_addr[0];
            default:              is_ex = 1'b0;
        endcase
    end

    assign is_excode = is_store ? `LSU_EXC_ADES : `LSU_EXC_ADEL;

    // replicate store data so every lane carries it
    always_comb begin
        st_word = wdata_q;
        data_be = 4'h0;
        case (op_q)
            OP_SB: begin
                for (int i = 0; i < 4; i++)
                    st_word.b[i] = wdata_q[7:0];
                data_be = 4'b0001 << is_addr[1:0];
            end
            OP_SH: begin
                st_word.h[0] = wdata_q[15:0];
                st_word.h[1] = wdata_q[15:0];
                data_be = is_addr[1] ? 4'b1100 : 4'b0011;
            end
            OP_SW: data_be = 4'hf;
            default: ;
        endcase
    end

    assign data_req   = is_valid && !is_ex && ms_allowin && !ms_flush;
    assign data_wr    = is_store;
    assign data_addr  = {is_addr[31:2], 2'b00};
    assign data_wdata = st_word;

endmodule

`default_nettype wire

// ==== lsu_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_stage
    import lsu_pkg::*;
(
    input  wire          clk,
    input  wire          reset,
    input  wire          is_to_ms_valid,
    input  wire mem_op_e is_op,
    input  wire [31:0]   is_addr,
    input  wire [4:0]    is_dest,
    input  wire          is_ex,
    input  wire [4:0]    is_excode,
    input  wire          ws_allowin,
    input  wire          data_ok,
    input  wire [31:0]   data_rdata,
    output logic         ms_allowin,
    output logic         ms_to_ws_valid,
    output logic [3:0]   ms_rf_we,
    output logic [4:0]   ms_dest,
    output logic [31:0]  ms_result,
    output logic         ms_ex,
    output logic [4:0]   ms_excode,
    output logic [31:0]  ms_badvaddr,
    output logic         ms_flush
);

    logic        ms_valid;
    logic        ms_ready_go;
    mem_op_e     op_q;
    logic [31:0] addr_q;
    logic [4:0]  dest_q;
    logic        ex_q;
    logic [4:0]  excode_q;
    logic [1:0]  pos;
    logic [3:0]  load_we;
    mem_word_u   rd;

    assign ms_ready_go    = ex_q || data_ok;
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= is_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (is_to_ms_valid && ms_allowin) begin
            op_q     <= is_op;
            addr_q   <= is_addr;
            dest_q   <= is_dest;
            ex_q     <= is_ex;
            excode_q <= is_excode;
        end
    end

    assign rd  = data_rdata;
    assign pos = addr_q[1:0];

    // align and extend, lwl/lwr only touch part of the register
    always_comb begin
        load_we = 4'hf;
        case (op_q)
            OP_LB:  ms_result = {{24{rd.b[pos][7]}}, rd.b[pos]};
            OP_LBU: ms_result = {24'b0, rd.b[pos]};
            OP_LH:  ms_result = {{16{rd.h[pos[1]][15]}}, rd.h[pos[1]]};
            OP_LHU: ms_result = {16'b0, rd.h[pos[1]]};
            OP_LWL: begin
                ms_result = data_rdata << {~pos, 3'b000};
                load_we   = {1'b1, pos != 2'd0, pos[1], pos == 2'd3};
            end
            OP_LWR: begin
                ms_result = data_rdata >> {pos, 3'b000};
                load_we   = {pos == 2'd0, ~pos[1], pos != 2'd3, 1'b1};
            end
            OP_LW:  ms_result = data_rdata;
            default: begin
                ms_result = data_rdata;
                load_we   = 4'h0;
            end
        endcase
    end

    assign ms_rf_we    = {4{ms_valid && !ex_q}} & load_we;
    assign ms_dest     = dest_q;
    assign ms_ex       = ms_valid && ex_q;
    assign ms_excode   = {5{ms_ex}} & excode_q;
    assign ms_badvaddr = addr_q;
    assign ms_flush    = ms_ex;

endmodule

`default_nettype wire

// ==== lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // load/store operations of the slice
    typedef enum logic [3:0] {
        OP_LW,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LWL,
        OP_LWR,
        OP_SW,
        OP_SB,
        OP_SH
    } mem_op_e;

    // one memory word, seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

endpackage

`default_nettype wire

// ==== lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data memory depth in 32-bit words
`define LSU_MEM_WORDS 256

// request accept to data_ok, 1 to 4 cycles
`define LSU_SRAM_LATENCY 2

// address error codes, load and store
`define LSU_EXC_ADEL 5'd4
`define LSU_EXC_ADES 5'd5

`endif

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  wire          clk,
    input  wire          reset,
    input  wire          in_valid,
    input  wire mem_op_e in_op,
    input  wire [31:0]   in_base,
    input  wire [15:0]   in_offset,
    input  wire [31:0]   in_wdata,
    input  wire [4:0]    in_dest,
    input  wire [4:0]    rf_raddr,
    output logic         in_allowin,
    output logic         wb_valid,
    output logic [4:0]   wb_dest,
    output logic [3:0]   wb_we,
    output logic         wb_ex,
    output logic [4:0]   wb_excode,
    output logic [31:0]  wb_badvaddr,
    output logic [31:0]  rf_rdata
);

    // issue to memory stage
    logic        is_to_ms_valid;
    mem_op_e     is_op;
    logic [31:0] is_addr;
    logic [4:0]  is_dest;
    logic        is_ex;
    logic [4:0]  is_excode;
    logic        ms_allowin;
    logic        ms_flush;

    // sram-like port
    logic        data_req;
    logic        data_wr;
    logic [3:0]  data_be;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_addr_ok;
    logic        data_ok;
    logic [31:0] data_rdata;

    // memory stage to writeback
    logic        ms_to_ws_valid;
    logic        ws_allowin;
    logic [3:0]  ms_rf_we;
    logic [4:0]  ms_dest;
    logic [31:0] ms_result;
    logic        ms_ex;
    logic [4:0]  ms_excode;
    logic [31:0] ms_badvaddr;

    lsu_issue_stage i_lsu_issue_stage (.*);

    lsu_mem_stage i_lsu_mem_stage (.*);

    lsu_wb_stage i_lsu_wb_stage (.*);

    lsu_data_sram i_lsu_data_sram (.*);

endmodule

`default_nettype wire

// ==== lsu_wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_wb_stage (
    input  wire         clk,
    input  wire         reset,
    input  wire         ms_to_ws_valid,
    input  wire  [3:0]  ms_rf_we,
    input  wire  [4:0]  ms_dest,
    input  wire  [31:0] ms_result,
    input  wire         ms_ex,
    input  wire  [4:0]  ms_excode,
    input  wire  [31:0] ms_badvaddr,
    input  wire  [4:0]  rf_raddr,
    output logic        ws_allowin,
    output logic        wb_valid,
    output logic [4:0]  wb_dest,
    output logic [3:0]  wb_we,
    output logic        wb_ex,
    output logic [4:0]  wb_excode,
    output logic [31:0] wb_badvaddr,
    output logic [31:0] rf_rdata
);

    logic        ws_valid;
    logic [3:0]  we_q;
    logic [4:0]  dest_q;
    logic [31:0] result_q;
    logic        ex_q;
    logic [4:0]  excode_q;
    logic [31:0] badvaddr_q;
    logic [31:0] rf [32];

    // nothing stalls past writeback
    assign ws_allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            we_q       <= ms_rf_we;
            dest_q     <= ms_dest;
            result_q   <= ms_result;
            ex_q       <= ms_ex;
            excode_q   <= ms_excode;
            badvaddr_q <= ms_badvaddr;
        end
    end

    // byte-wise commit, r0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                rf[i] <= 32'b0;
        end else if (ws_valid && dest_q != 5'd0) begin
            for (int i = 0; i < 4; i++)
                if (we_q[i])
                    rf[dest_q][i*8 +: 8] <= result_q[i*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ws_valid) begin
            wb_dest     <= dest_q;
            wb_we       <= we_q;
            wb_ex       <= ex_q;
            wb_excode   <= excode_q;
            wb_badvaddr <= badvaddr_q;
        end
    end

    assign rf_rdata = rf[rf_raddr];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_lsu -o sim_lsu

./obj_dir/sim_lsu | tee sim.log

if grep -q "^all tests passed$" sim.log; then
    exit 0
else
    exit 1
fi

// ==== sources.f ====
+incdir+.
lsu_pkg.sv
lsu_issue_stage.sv
lsu_mem_stage.sv
lsu_wb_stage.sv
lsu_data_sram.sv
lsu_top.sv
lsu_chk.sv
tb_lsu.sv

// ==== tb_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module tb_lsu
    import lsu_pkg::*;
();

    localparam int DRIVE_DLY = 5;
    localparam int TIMEOUT   = 20 + 10 * `LSU_SRAM_LATENCY;
    localparam int N_RAND    = 40;

    logic        clk;
    logic        reset;
    logic        in_valid;
    mem_op_e     in_op;
    logic [31:0] in_base;
    logic [15:0] in_offset;
    logic [31:0] in_wdata;
    logic [4:0]  in_dest;
    logic [4:0]  rf_raddr;
    logic        in_allowin;
    logic        wb_valid;
    logic [4:0]  wb_dest;
    logic [3:0]  wb_we;
    logic        wb_ex;
    logic [4:0]  wb_excode;
    logic [31:0] wb_badvaddr;
    logic [31:0] rf_rdata;

    // reference models
    logic [31:0] ref_mem [`LSU_MEM_WORDS];
    logic [31:0] ref_rf [32];

    // expected commits, oldest first
    logic [4:0]  exp_dest_q [$];
    logic [3:0]  exp_we_q [$];
    logic        exp_ex_q [$];
    logic [4:0]  exp_code_q [$];
    logic [31:0] exp_bad_q [$];
    mem_word_u   exp_val_q [$];

    int          errors;
    bit          timed_out;
    logic [31:0] lfsr;

    lsu_top i_lsu_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = 32'h0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return 32'h9e37_79b9 * ({24'h0, idx} + 32'd1);
    endfunction

    task automatic check_word(input string name, input mem_word_u got, input mem_word_u exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_we(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_dest(input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            $display("error wb_dest: got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_exc(input logic got_ex, input logic [4:0] got_code,
                             input logic [31:0] got_bad, input logic exp_ex,
                             input logic [4:0] exp_code, input logic [31:0] exp_bad);
        if (got_ex !== exp_ex) begin
            $display("error wb_ex: got %h expected %h", got_ex, exp_ex);
            errors++;
        end
        if (got_code !== exp_code) begin
            $display("error wb_excode: got %h expected %h", got_code, exp_code);
            errors++;
        end
        if (exp_ex && got_bad !== exp_bad) begin
            $display("error wb_badvaddr: got %h expected %h", got_bad, exp_bad);
            errors++;
        end
    endtask

    // apply one op to the reference models and queue its commit
    task automatic model_op(input mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [4:0] dest);
        logic [7:0] idx;
        logic [1:0] p;
        int         pi;
        mem_word_u  w;
        mem_word_u  nv;
        mem_word_u  sd;
        mem_word_u  rr;
        logic [3:0] we;
        logic       ex;
        logic       st;
        logic [4:0] code;
        idx  = addr[9:2];
        p    = addr[1:0];
        pi   = int'(p);
        w    = ref_mem[idx];
        nv   = 32'h0;
        sd   = wdata;
        we   = 4'h0;
        code = 5'd0;
        st   = (op == OP_SW) || (op == OP_SB) || (op == OP_SH);
        case (op)
            OP_LW, OP_SW:         ex = (p != 2'd0);
            OP_LH, OP_LHU, OP_SH: ex = p[0];
            default:              ex = 1'b0;
        endcase
        if (ex) begin
            code = st ? `LSU_EXC_ADES : `LSU_EXC_ADEL;
        end else begin
            case (op)
                OP_LW: begin
                    nv = w;
                    we = 4'hf;
                end
                OP_LB, OP_LBU: begin
                    for (int i = 0; i < 4; i++)
                        nv.b[i] = (i == 0) ? w.b[p] :
                                  ((op == OP_LB && w.b[p][7]) ? 8'hff : 8'h00);
                    we = 4'hf;
                end
                OP_LH, OP_LHU: begin
                    nv.h[0] = w.h[p[1]];
                    nv.h[1] = (op == OP_LH && w.h[p[1]][15]) ? 16'hffff : 16'h0000;
                    we      = 4'hf;
                end
                // left part: low memory bytes land in the top of the register
                OP_LWL: begin
                    for (int i = 0; i < 4; i++)
                        if (i >= 3 - pi) begin
                            nv.b[i] = w.b[i - (3 - pi)];
                            we[i]   = 1'b1;
                        end
                end
                OP_LWR: begin
                    for (int i = 0; i < 4; i++)
                        if (i <= 3 - pi) begin
                            nv.b[i] = w.b[i + pi];
                            we[i]   = 1'b1;
                        end
                end
                OP_SW: ref_mem[idx] = wdata;
                OP_SB: begin
                    w.b[p]       = sd.b[0];
                    ref_mem[idx] = w;
                end
                OP_SH: begin
                    w.h[p[1]]    = sd.h[0];
                    ref_mem[idx] = w;
                end
                default: ;
            endcase
        end
        if (dest != 5'd0) begin
            rr = ref_rf[dest];
            for (int i = 0; i < 4; i++)
                if (we[i])
                    rr.b[i] = nv.b[i];
            ref_rf[dest] = rr;
        end
        exp_dest_q.push_back(dest);
        exp_we_q.push_back(we);
        exp_ex_q.push_back(ex);
        exp_code_q.push_back(code);
        exp_bad_q.push_back(addr);
        exp_val_q.push_back(ref_rf[dest]);
    endtask

    task automatic send(input mem_op_e op, input logic [31:0] base, input logic [15:0] off,
                        input logic [31:0] wdata, input logic [4:0] dest);
        bit accepted;
        int cnt;
        accepted  = 1'b0;
        cnt       = 0;
        in_valid  = 1'b1;
        in_op     = op;
        in_base   = base;
        in_offset = off;
        in_wdata  = wdata;
        in_dest   = dest;
        while (!accepted && !timed_out) begin
            accepted = in_allowin;
            @(posedge clk);
            #DRIVE_DLY;
            cnt++;
            if (!accepted && cnt > TIMEOUT) begin
                $display("timeout: the issue stage never accepted an operation");
                timed_out = 1'b1;
                errors++;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_commit();
        bit seen;
        int cnt;
        seen = 1'b0;
        cnt  = 0;
        while (!seen && !timed_out) begin
            @(posedge clk);
            #1;
            seen = wb_valid;
            cnt++;
            if (!seen && cnt > TIMEOUT) begin
                $display("timeout: no commit arrived on wb_valid");
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic check_commit();
        mem_word_u got;
        if (timed_out)
            return;
        if (exp_dest_q.size() == 0) begin
            $display("a commit arrived while no operation was expected");
            errors++;
            return;
        end
        rf_raddr = exp_dest_q[0];
        #1;
        got = rf_rdata;
        check_dest(wb_dest, exp_dest_q.pop_front());
        check_we("wb_we", wb_we, exp_we_q.pop_front());
        check_exc(wb_ex, wb_excode, wb_badvaddr, exp_ex_q.pop_front(),
                  exp_code_q.pop_front(), exp_bad_q.pop_front());
        check_word("rf_rdata", got, exp_val_q.pop_front());
    endtask

    task automatic run_op(input mem_op_e op, input logic [31:0] base, input logic [15:0] off,
                          input logic [31:0] wdata, input logic [4:0] dest);
        model_op(op, base + {{16{off[15]}}, off}, wdata, dest);
        send(op, base, off, wdata, dest);
        wait_commit();
        check_commit();
    endtask

    task automatic fill_memory();
        for (int i = 0; i < `LSU_MEM_WORDS; i++)
            run_op(OP_SW, 32'(i * 4), 16'h0, fill_word(8'(i)), 5'd0);
    endtask

    task automatic test_sub_word_loads();
        run_op(OP_SW, 32'h40, 16'h0, 32'h80ff_7f01, 5'd0);
        run_op(OP_LW, 32'h50, 16'hfff0, 32'h0, 5'd1);
        for (int p = 0; p < 4; p++) begin
            run_op(OP_LB, 32'h40, 16'(p), 32'h0, 5'd2);
            run_op(OP_LBU, 32'h50, 16'(p - 16), 32'h0, 5'd3);
        end
        for (int p = 0; p < 4; p += 2) begin
            run_op(OP_LH, 32'h40, 16'(p), 32'h0, 5'd4);
            run_op(OP_LHU, 32'h40, 16'(p), 32'h0, 5'd5);
        end
    endtask

    task automatic test_lwl_lwr();
        for (int p = 0; p < 4; p++) begin
            run_op(OP_LW, 32'h200, 16'h0, 32'h0, 5'd10);
            run_op(OP_LWL, 32'h80, 16'(p), 32'h0, 5'd10);
            run_op(OP_LW, 32'h204, 16'h0, 32'h0, 5'd11);
            run_op(OP_LWR, 32'h80, 16'(p), 32'h0, 5'd11);
        end
    endtask

    task automatic test_byte_stores();
        for (int p = 0; p < 4; p++) begin
            run_op(OP_SB, 32'h100, 16'(p), 32'h1234_5600 + 32'(p), 5'd0);
            run_op(OP_LW, 32'h100, 16'h0, 32'h0, 5'd12);
        end
        for (int p = 0; p < 4; p += 2) begin
            run_op(OP_SH, 32'h104, 16'(p), 32'hdead_be00 + 32'(p), 5'd0);
            run_op(OP_LW, 32'h104, 16'h0, 32'h0, 5'd13);
        end
    endtask

    // the op right behind a fault is killed, the one after it commits
    task automatic test_fault_kill();
        run_op(OP_SW, 32'h300, 16'h0, 32'h5566_7788, 5'd0);
        model_op(OP_LW, 32'h301, 32'h0, 5'd5);
        model_op(OP_LW, 32'h300, 32'h0, 5'd6);
        model_op(OP_SH, 32'h303, 32'h0, 5'd0);
        model_op(OP_LW, 32'h300, 32'h0, 5'd8);
        fork
            begin
                send(OP_LW, 32'h300, 16'h1, 32'h0, 5'd5);
                send(OP_SW, 32'h300, 16'h0, 32'hffff_ffff, 5'd0);
                send(OP_LW, 32'h300, 16'h0, 32'h0, 5'd6);
                send(OP_SH, 32'h300, 16'h3, 32'hffff_ffff, 5'd0);
                send(OP_LW, 32'h300, 16'h0, 32'h0, 5'd7);
                send(OP_LW, 32'h300, 16'h0, 32'h0, 5'd8);
            end
            begin
                for (int i = 0; i < 4; i++) begin
                    wait_commit();
                    check_commit();
                end
            end
        join
    endtask

    task automatic test_random_burst();
        mem_op_e     ops [N_RAND];
        logic [31:0] bases [N_RAND];
        logic [15:0] offs [N_RAND];
        logic [31:0] wdatas [N_RAND];
        logic [4:0]  dests [N_RAND];
        logic [31:0] addr;
        logic [7:0]  idx;
        logic [1:0]  p;
        logic [5:0]  r;
        for (int i = 0; i < N_RAND; i++) begin
            ops[i] = mem_op_e'(4'(rand_bits(4) % 10));
            idx    = 8'(rand_bits(8));
            p      = 2'(rand_bits(2));
            if (ops[i] == OP_LW || ops[i] == OP_SW)
                p = 2'd0;
            if (ops[i] == OP_LH || ops[i] == OP_LHU || ops[i] == OP_SH)
                p[0] = 1'b0;
            r         = 6'(rand_bits(6));
            offs[i]   = {{10{r[5]}}, r};
            addr      = {22'h0, idx, p};
            bases[i]  = addr - {{16{offs[i][15]}}, offs[i]};
            dests[i]  = 5'(rand_bits(5));
            wdatas[i] = rand_bits(32);
            model_op(ops[i], addr, wdatas[i], dests[i]);
        end
        fork
            begin
                for (int i = 0; i < N_RAND; i++)
                    send(ops[i], bases[i], offs[i], wdatas[i], dests[i]);
            end
            begin
                for (int i = 0; i < N_RAND; i++) begin
                    wait_commit();
                    check_commit();
                end
            end
        join
    endtask

    initial begin
        errors    = 0;
        timed_out = 1'b0;
        lfsr      = 32'd67851;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_op     = OP_LW;
        in_base   = 32'h0;
        in_offset = 16'h0;
        in_wdata  = 32'h0;
        in_dest   = 5'd0;
        rf_raddr  = 5'd0;
        for (int i = 0; i < 32; i++)
            ref_rf[i] = 32'h0;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        fill_memory();
        test_sub_word_loads();
        test_lwl_lwr();
        test_byte_stores();
        test_fault_kill();
        test_random_burst();
        if (exp_dest_q.size() != 0) begin
            $display("%0d expected commits never arrived", exp_dest_q.size());
            errors++;
        end

        $display("errors: %0d", errors);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
